//--- filelist.f
+incdir+src
+incdir+bench
src/cpu_pkg.sv
src/block_ram.sv
src/page_translator.sv
src/core_sequencer.sv
src/trace_port.sv
src/cpu_top.sv
bench/tb_cpu.sv

//--- Makefile
# Verilator build and run of the processor testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
FAIL_MSG  ?= SOME TESTS FAILED

.PHONY: sim clean

# build, run, then scan the log for the failure message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_cpu_table.svh
`ifndef TB_CPU_TABLE_SVH
`define TB_CPU_TABLE_SVH

// program image, loaded at physical 0 where logical page 0 already lives
localparam int PROG_WORDS  = 34;
localparam int PROG_INSTRS = PROG_WORDS / 2;
localparam int EXP_EVENTS  = 11;

cpu_pkg::word_t prog_words [PROG_WORDS] = '{
  {`CPU_OP_NUM2REG,   8'h01}, 16'h0005,  // 0: r1 = 5
  {`CPU_OP_NUM2REG,   8'h02}, 16'hfffe,  // 2: r2 = 0xfffe
  {`CPU_OP_REG_PLUS,  8'h02}, 16'h0005,  // 4: r2 wraps to 3
  {`CPU_OP_REG_MINUS, 8'h01}, 16'h0007,  // 6: r1 wraps to 0xfffe
  {`CPU_OP_REG2RAM,   8'h01}, 16'h014a,  // 8: logical page 5 gets physical page 1
  {`CPU_OP_REG2RAM,   8'h02}, 16'h00c7,  // 10: logical page 3 gets physical page 2
  {`CPU_OP_NUM2REG,   8'h0b}, 16'h1234,  // 12: only the low 3 bits pick r3
  {`CPU_OP_REG2RAM,   8'h03}, 16'h0154,  // 14: page 5 again, reuses page 1
  {`CPU_OP_RAM2REG,   8'h04}, 16'h014a,  // 16: r4 reads back the first store
  {`CPU_OP_JMP,       8'h00}, 16'h0018,  // 18: skip to 24
  {`CPU_OP_NUM2REG,   8'h05}, 16'h1111,  // 20: skipped
  {`CPU_OP_NUM2REG,   8'h06}, 16'h2222,  // 22: skipped
  {8'h09,             8'h07}, 16'h5555,  // 24: unknown opcode, no event
  {`CPU_OP_REG_PLUS,  8'h04}, 16'h0003,  // 26: r4 wraps to 1
  {`CPU_OP_RAM2REG,   8'h00}, 16'h00c7,  // 28: r0 reads back the page 3 store
  {`CPU_OP_EXIT,      8'h00}, 16'h0000,  // 30: halt
  {`CPU_OP_NUM2REG,   8'h05}, 16'h7777   // 32: never reached
};

// expected trace, one column per field, in arrival order
cpu_pkg::trace_kind_t exp_kind [EXP_EVENTS] = '{
  cpu_pkg::TRACE_REG,   cpu_pkg::TRACE_REG,   cpu_pkg::TRACE_REG,
  cpu_pkg::TRACE_REG,   cpu_pkg::TRACE_STORE, cpu_pkg::TRACE_STORE,
  cpu_pkg::TRACE_REG,   cpu_pkg::TRACE_STORE, cpu_pkg::TRACE_REG,
  cpu_pkg::TRACE_REG,   cpu_pkg::TRACE_REG
};

cpu_pkg::addr_t exp_index [EXP_EVENTS] = '{
  10'h001, 10'h002, 10'h002,
  10'h001, 10'h04a, 10'h087,  // page 1 offset 10, page 2 offset 7
  10'h003, 10'h054, 10'h004,  // page 1 offset 20
  10'h004, 10'h000
};

cpu_pkg::word_t exp_data [EXP_EVENTS] = '{
  16'h0005, 16'hfffe, 16'h0003,
  16'hfffe, 16'hfffe, 16'h0003,
  16'h1234, 16'h1234, 16'hfffe,
  16'h0001, 16'h0003
};

`endif

//--- bench/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;

  `include "tb_cpu_table.svh"

  localparam int TIMEOUT_CYCLES = 60 * PROG_INSTRS + 200;

  logic                 clka = 1'b0;
  logic                 arst_n;
  logic                 load_en;
  cpu_pkg::addr_t       load_addr;
  cpu_pkg::word_t       load_data;
  logic                 run;
  logic                 credit_return = 1'b0;
  logic                 trace_valid;
  cpu_pkg::trace_kind_t trace_kind;
  cpu_pkg::addr_t       trace_index;
  cpu_pkg::word_t       trace_data;
  logic                 halted;

  integer      seed = 32633;
  logic [31:0] rnd;
  int          rcv_cnt = 0;    // events seen on the trace port
  int          crd_cnt = 0;    // credits handed back
  int          hold_cnt = 80;  // credits held at the start so the core stalls early
  int          cycle_cnt = 0;
  int          value_errs = 0;
  int          flow_errs = 0;
  int          run_errs = 0;

  cpu_top dut0 (
    .clka          (clka),
    .arst_n        (arst_n),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .run           (run),
    .credit_return (credit_return),
    .trace_valid   (trace_valid),
    .trace_kind    (trace_kind),
    .trace_index   (trace_index),
    .trace_data    (trace_data),
    .halted        (halted)
  );

  always #10 clka = ~clka;

  task automatic report_mismatch(input string name, input int unsigned expected,
                                 input int unsigned actual);
    $display("FAILED t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    value_errs = value_errs + 1;
  endtask

  always @(posedge clka) begin
    if (run) begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // credit return, random rate with occasional long stalls
  always @(posedge clka) begin
    credit_return <= 1'b0;
    if (run) begin
      rnd = $random(seed);
      if (hold_cnt > 0) begin
        hold_cnt = hold_cnt - 1;
      end else if (rnd[5:0] == 6'd0) begin
        hold_cnt = 16 + 2 * int'(rnd[9:6]);
      end else if (rnd[1] && (rcv_cnt > crd_cnt)) begin
        credit_return <= 1'b1;
        crd_cnt = crd_cnt + 1;
      end
    end
  end

  // trace monitor, sampled mid cycle
  always @(negedge clka) begin
    if (arst_n && trace_valid) begin
      if (halted) begin
        $display("event %0d at %0t arrived after the core halted", rcv_cnt, $time);
        flow_errs = flow_errs + 1;
      end
      if (rcv_cnt >= EXP_EVENTS) begin
        $display("extra event %0d at %0t beyond the expected trace", rcv_cnt, $time);
        flow_errs = flow_errs + 1;
      end else begin
        if (trace_kind != exp_kind[rcv_cnt]) begin
          report_mismatch("trace_kind", 32'(exp_kind[rcv_cnt]), 32'(trace_kind));
        end
        if (trace_index != exp_index[rcv_cnt]) begin
          report_mismatch("trace_index", 32'(exp_index[rcv_cnt]), 32'(trace_index));
        end
        if (trace_data != exp_data[rcv_cnt]) begin
          report_mismatch("trace_data", 32'(exp_data[rcv_cnt]), 32'(trace_data));
        end
      end
      rcv_cnt = rcv_cnt + 1;
      if (rcv_cnt - crd_cnt > `CPU_TRACE_CREDITS) begin
        $display("more than %0d events at %0t without a credit return",
                 `CPU_TRACE_CREDITS, $time);
        flow_errs = flow_errs + 1;
      end
    end
  end

  initial begin
    arst_n    = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    run       = 1'b0;
    repeat (3) @(posedge clka);
    arst_n <= 1'b1;

    for (int i = 0; i < PROG_WORDS; i++) begin
      @(posedge clka);
      load_en   <= 1'b1;
      load_addr <= cpu_pkg::addr_t'(i);
      load_data <= prog_words[i];
    end
    @(posedge clka);
    load_en <= 1'b0;
    repeat (2) @(posedge clka);
    run <= 1'b1;

    while (!halted && cycle_cnt < TIMEOUT_CYCLES) begin
      @(negedge clka);
    end
    if (!halted) begin
      $display("timeout after %0d cycles, the core never halted", cycle_cnt);
      run_errs = run_errs + 1;
    end else begin
      // quiet window up to the limit, nothing may follow exit
      while (cycle_cnt < TIMEOUT_CYCLES) begin
        @(negedge clka);
      end
    end
    @(posedge clka);

    if (rcv_cnt < EXP_EVENTS) begin
      $display("missing events, only %0d of %0d arrived", rcv_cnt, EXP_EVENTS);
      run_errs = run_errs + 1;
    end
    $display("errors: %0d value, %0d flow, %0d run, events %0d of %0d",
             value_errs, flow_errs, run_errs, rcv_cnt, EXP_EVENTS);
    if (value_errs + flow_errs + run_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                 clka,
  input  logic                 arst_n,
  input  logic                 load_en,
  input  cpu_pkg::addr_t       load_addr,
  input  cpu_pkg::word_t       load_data,
  input  logic                 run,
  input  logic                 credit_return,
  output logic                 trace_valid,
  output cpu_pkg::trace_kind_t trace_kind,
  output cpu_pkg::addr_t       trace_index,
  output cpu_pkg::word_t       trace_data,
  output logic                 halted
);

  logic                 wr_en;
  cpu_pkg::addr_t       wr_addr;
  cpu_pkg::word_t       wr_data;
  cpu_pkg::addr_t       rd_addr;
  cpu_pkg::word_t       rd_data;
  logic                 xlat_req;
  cpu_pkg::addr_t       xlat_logical;
  logic                 xlat_done;
  cpu_pkg::addr_t       xlat_physical;
  logic                 ev_push;
  cpu_pkg::trace_kind_t ev_kind;
  cpu_pkg::addr_t       ev_index;
  cpu_pkg::word_t       ev_data;
  logic                 ev_ready;

  block_ram ram0 (
    .clka    (clka),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  page_translator xlat0 (
    .clka          (clka),
    .arst_n        (arst_n),
    .xlat_req      (xlat_req),
    .xlat_logical  (xlat_logical),
    .xlat_done     (xlat_done),
    .xlat_physical (xlat_physical)
  );

  core_sequencer seq0 (
    .clka          (clka),
    .arst_n        (arst_n),
    .run           (run),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .xlat_req      (xlat_req),
    .xlat_logical  (xlat_logical),
    .xlat_done     (xlat_done),
    .xlat_physical (xlat_physical),
    .ev_push       (ev_push),
    .ev_kind       (ev_kind),
    .ev_index      (ev_index),
    .ev_data       (ev_data),
    .ev_ready      (ev_ready),
    .halted        (halted)
  );

  trace_port trace0 (
    .clka          (clka),
    .arst_n        (arst_n),
    .ev_push       (ev_push),
    .ev_kind       (ev_kind),
    .ev_index      (ev_index),
    .ev_data       (ev_data),
    .ev_ready      (ev_ready),
    .credit_return (credit_return),
    .trace_valid   (trace_valid),
    .trace_kind    (trace_kind),
    .trace_index   (trace_index),
    .trace_data    (trace_data)
  );

endmodule

//--- src/trace_port.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module trace_port (
  input  logic                 clka,
  input  logic                 arst_n,
  input  logic                 ev_push,
  input  cpu_pkg::trace_kind_t ev_kind,
  input  cpu_pkg::addr_t       ev_index,
  input  cpu_pkg::word_t       ev_data,
  output logic                 ev_ready,
  input  logic                 credit_return,
  output logic                 trace_valid,
  output cpu_pkg::trace_kind_t trace_kind,
  output cpu_pkg::addr_t       trace_index,
  output cpu_pkg::word_t       trace_data
);

  localparam int CNT_BITS = $clog2(`CPU_TRACE_CREDITS + 1);

  logic [CNT_BITS-1:0] credit_cnt;

  assign ev_ready = (credit_cnt != '0);

  always_ff @(posedge clka or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt  <= CNT_BITS'(`CPU_TRACE_CREDITS);
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= ev_push;  // one cycle per event
      case ({ev_push, credit_return})
        2'b10:   credit_cnt <= credit_cnt - CNT_BITS'(1);
        2'b01:   credit_cnt <= credit_cnt + CNT_BITS'(1);
        default: credit_cnt <= credit_cnt;  // both or neither cancel out
      endcase
    end
  end

  // event payload
  always_ff @(posedge clka) begin
    if (ev_push) begin
      trace_kind  <= ev_kind;
      trace_index <= ev_index;
      trace_data  <= ev_data;
    end
  end

  // the receiver never hands back more than it was given
  credit_bound: assert property (@(posedge clka) disable iff (!arst_n)
    credit_cnt <= CNT_BITS'(`CPU_TRACE_CREDITS));

  // the sequencer only pushes while a credit is held
  push_has_credit: assert property (@(posedge clka) disable iff (!arst_n)
    ev_push |-> (credit_cnt != '0));

endmodule

//--- src/core_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module core_sequencer (
  input  logic                 clka,
  input  logic                 arst_n,
  input  logic                 run,
  input  logic                 load_en,
  input  cpu_pkg::addr_t       load_addr,
  input  cpu_pkg::word_t       load_data,
  output logic                 wr_en,
  output cpu_pkg::addr_t       wr_addr,
  output cpu_pkg::word_t       wr_data,
  output cpu_pkg::addr_t       rd_addr,
  input  cpu_pkg::word_t       rd_data,
  output logic                 xlat_req,
  output cpu_pkg::addr_t       xlat_logical,
  input  logic                 xlat_done,
  input  cpu_pkg::addr_t       xlat_physical,
  output logic                 ev_push,
  output cpu_pkg::trace_kind_t ev_kind,
  output cpu_pkg::addr_t       ev_index,
  output cpu_pkg::word_t       ev_data,
  input  logic                 ev_ready,
  output logic                 halted
);

  localparam int REG_BITS = $bits(cpu_pkg::reg_idx_t);

  typedef enum logic [3:0] {
    S_IDLE,
    S_WAIT_OP,
    S_READ_OP,
    S_LATCH_OP,
    S_WAIT_ARG,
    S_READ_ARG,
    S_LATCH_ARG,
    S_EXEC,
    S_WAIT_DATA,
    S_READ_DATA,
    S_LOAD_WB,
    S_STORE,
    S_HALT
  } seq_state_t;

  seq_state_t         state;
  cpu_pkg::addr_t     pc;
  cpu_pkg::word_t     regs [`CPU_NUM_REGS];
  cpu_pkg::opcode_t   inst_op;
  cpu_pkg::reg_idx_t  inst_reg;
  cpu_pkg::word_t     operand;
  cpu_pkg::addr_t     data_phys;  // translated store address
  cpu_pkg::word_t     reg_val;
  cpu_pkg::addr_t     next_pc;
  logic               is_arith;
  logic               is_mem;
  logic               reg_wr;
  logic               store_go;
  logic               fetch_go;

  assign is_arith = inst_op inside {cpu_pkg::OP_NUM2REG, cpu_pkg::OP_REG_PLUS,
                                    cpu_pkg::OP_REG_MINUS};
  assign is_mem   = inst_op inside {cpu_pkg::OP_RAM2REG, cpu_pkg::OP_REG2RAM};

  // writes and stores wait for a trace credit
  assign reg_wr   = ev_ready && (((state == S_EXEC) && is_arith) || (state == S_LOAD_WB));
  assign store_go = ev_ready && (state == S_STORE);
  assign fetch_go = reg_wr || store_go ||
                    ((state == S_EXEC) && !is_arith && !is_mem &&
                     (inst_op != cpu_pkg::OP_EXIT));  // jmp and no-ops move on at once

  assign next_pc = ((state == S_EXEC) && (inst_op == cpu_pkg::OP_JMP)) ?
                   operand[`CPU_ADDR_BITS-1:0] : pc;

  always_comb begin
    reg_val = operand;  // num2reg
    if (state == S_LOAD_WB) begin
      reg_val = rd_data;
    end else if (inst_op == cpu_pkg::OP_REG_PLUS) begin
      reg_val = regs[inst_reg] + operand;  // wraps at 16 bits
    end else if (inst_op == cpu_pkg::OP_REG_MINUS) begin
      reg_val = regs[inst_reg] - operand;
    end
  end

  always_ff @(posedge clka or negedge arst_n) begin
    if (!arst_n) begin
      state        <= S_IDLE;
      pc           <= '0;
      halted       <= 1'b0;
      wr_en        <= 1'b0;
      wr_addr      <= '0;
      wr_data      <= '0;
      rd_addr      <= '0;
      xlat_req     <= 1'b0;
      xlat_logical <= '0;
      ev_push      <= 1'b0;
      ev_kind      <= cpu_pkg::TRACE_REG;
      ev_index     <= '0;
      ev_data      <= '0;
      inst_op      <= cpu_pkg::OP_JMP;
      inst_reg     <= '0;
      operand      <= '0;
      data_phys    <= '0;
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      wr_en    <= 1'b0;
      xlat_req <= 1'b0;
      ev_push  <= 1'b0;

      case (state)
        S_IDLE: begin
          wr_en   <= load_en && !run;  // program load path
          wr_addr <= load_addr;
          wr_data <= load_data;
          if (run) begin
            pc           <= '0;
            xlat_req     <= 1'b1;
            xlat_logical <= '0;
            state        <= S_WAIT_OP;
          end
        end
        S_WAIT_OP: begin
          if (xlat_done) begin
            rd_addr <= xlat_physical;
            state   <= S_READ_OP;
          end
        end
        S_READ_OP: state <= S_LATCH_OP;  // ram latency
        S_LATCH_OP: begin
          inst_op      <= cpu_pkg::opcode_t'(rd_data[15:8]);
          inst_reg     <= rd_data[REG_BITS-1:0];
          xlat_req     <= 1'b1;
          xlat_logical <= pc + cpu_pkg::addr_t'(1);
          state        <= S_WAIT_ARG;
        end
        S_WAIT_ARG: begin
          if (xlat_done) begin
            rd_addr <= xlat_physical;
            state   <= S_READ_ARG;
          end
        end
        S_READ_ARG: state <= S_LATCH_ARG;
        S_LATCH_ARG: begin
          operand <= rd_data;
          pc      <= pc + cpu_pkg::addr_t'(2);
          state   <= S_EXEC;
        end
        S_EXEC: begin
          if (is_mem) begin
            xlat_req     <= 1'b1;
            xlat_logical <= operand[`CPU_ADDR_BITS-1:0];
            state        <= S_WAIT_DATA;
          end else if (inst_op == cpu_pkg::OP_EXIT) begin
            halted <= 1'b1;
            state  <= S_HALT;
          end
        end
        S_WAIT_DATA: begin
          if (xlat_done) begin
            if (inst_op == cpu_pkg::OP_RAM2REG) begin
              rd_addr <= xlat_physical;
              state   <= S_READ_DATA;
            end else begin
              data_phys <= xlat_physical;
              state     <= S_STORE;
            end
          end
        end
        S_READ_DATA: state <= S_LOAD_WB;
        S_LOAD_WB, S_STORE, S_HALT: ;  // leave through fetch_go, or stay halted
        default: state <= S_IDLE;
      endcase

      if (reg_wr) begin
        regs[inst_reg] <= reg_val;
        ev_push        <= 1'b1;
        ev_kind        <= cpu_pkg::TRACE_REG;
        ev_index       <= cpu_pkg::addr_t'(inst_reg);
        ev_data        <= reg_val;
      end

      if (store_go) begin
        wr_en    <= 1'b1;
        wr_addr  <= data_phys;
        wr_data  <= regs[inst_reg];
        ev_push  <= 1'b1;
        ev_kind  <= cpu_pkg::TRACE_STORE;
        ev_index <= data_phys;
        ev_data  <= regs[inst_reg];
      end

      if (fetch_go) begin
        pc           <= next_pc;
        xlat_req     <= 1'b1;
        xlat_logical <= next_pc;
        state        <= S_WAIT_OP;
      end
    end
  end

  // a store write outside the load phase always carries its trace event
  store_with_event: assert property (@(posedge clka) disable iff (!arst_n)
    (wr_en && ($past(state) != S_IDLE)) |->
      (ev_push && (ev_kind == cpu_pkg::TRACE_STORE) && $past(ev_ready)));

endmodule

//--- src/page_translator.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module page_translator (
  input  logic           clka,
  input  logic           arst_n,
  input  logic           xlat_req,
  input  cpu_pkg::addr_t xlat_logical,
  output logic           xlat_done,
  output cpu_pkg::addr_t xlat_physical
);

  localparam int OFF_BITS = `CPU_PAGE_BITS;

  typedef enum logic [1:0] {
    T_IDLE,
    T_WALK,
    T_SCAN
  } xlat_state_t;

  xlat_state_t          state;
  cpu_pkg::page_t       chain_next [`CPU_NUM_PAGES];  // tail points at itself
  cpu_pkg::page_t       page_owner [`CPU_NUM_PAGES];  // logical page held by each physical page
  logic [`CPU_NUM_PAGES-1:0] used;
  cpu_pkg::page_t       free_ptr;                     // lowest page that may still be free
  cpu_pkg::page_t       cur_page;                     // walk position
  cpu_pkg::page_t       scan_page;                    // allocation candidate
  cpu_pkg::page_t       cache_log;
  cpu_pkg::page_t       cache_phys;
  cpu_pkg::page_t       req_page;
  logic [OFF_BITS-1:0]  req_off;
  cpu_pkg::page_t       in_page;
  logic                 alloc;
  logic                 found;
  cpu_pkg::page_t       found_page;

  assign in_page = xlat_logical[`CPU_ADDR_BITS-1:OFF_BITS];

  assign alloc      = (state == T_SCAN) && !used[scan_page];
  assign found      = ((state == T_WALK) && (page_owner[cur_page] == req_page)) || alloc;
  assign found_page = alloc ? scan_page : cur_page;

  always_ff @(posedge clka or negedge arst_n) begin
    if (!arst_n) begin
      state         <= T_IDLE;
      xlat_done     <= 1'b0;
      xlat_physical <= '0;
      for (int i = 0; i < `CPU_NUM_PAGES; i++) begin
        chain_next[i] <= '0;
        page_owner[i] <= '0;
      end
      used       <= {{(`CPU_NUM_PAGES-1){1'b0}}, 1'b1};  // page 0 starts the chain
      free_ptr   <= cpu_pkg::page_t'(1);
      cur_page   <= '0;
      scan_page  <= '0;
      cache_log  <= '0;                                  // logical 0 lives on page 0
      cache_phys <= '0;
      req_page   <= '0;
      req_off    <= '0;
    end else begin
      xlat_done <= 1'b0;
      case (state)
        T_IDLE: begin
          if (xlat_req) begin
            req_page <= in_page;
            req_off  <= xlat_logical[OFF_BITS-1:0];
            if (in_page == cache_log) begin
              xlat_done     <= 1'b1;  // cache hit
              xlat_physical <= {cache_phys, xlat_logical[OFF_BITS-1:0]};
            end else begin
              cur_page <= '0;
              state    <= T_WALK;
            end
          end
        end
        T_WALK: begin
          if (!found) begin
            if (chain_next[cur_page] == cur_page) begin
              scan_page <= free_ptr;  // end of chain, go allocate
              state     <= T_SCAN;
            end else begin
              cur_page <= chain_next[cur_page];
            end
          end
        end
        T_SCAN: begin
          if (alloc) begin
            chain_next[cur_page]  <= scan_page;  // append to tail
            chain_next[scan_page] <= scan_page;
            page_owner[scan_page] <= req_page;
            used[scan_page]       <= 1'b1;
            free_ptr              <= scan_page + cpu_pkg::page_t'(1);
          end else begin
            scan_page <= scan_page + cpu_pkg::page_t'(1);
          end
        end
        default: state <= T_IDLE;
      endcase

      if (found) begin
        xlat_done     <= 1'b1;
        xlat_physical <= {found_page, req_off};
        cache_log     <= req_page;
        cache_phys    <= found_page;
        state         <= T_IDLE;
      end
    end
  end

  // a done always closes a request that was accepted earlier
  done_has_request: assert property (@(posedge clka) disable iff (!arst_n)
    xlat_done |-> ($past(xlat_req) || ($past(state) != T_IDLE)));

  // pages below the pick are all taken, so the pick is the lowest free page
  alloc_free_page: assert property (@(posedge clka) disable iff (!arst_n)
    alloc |-> ((used | ~((`CPU_NUM_PAGES'(1) << scan_page) - `CPU_NUM_PAGES'(1))) == '1));

endmodule

//--- src/block_ram.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module block_ram (
  input  logic           clka,
  input  logic           wr_en,
  input  cpu_pkg::addr_t wr_addr,
  input  cpu_pkg::word_t wr_data,
  input  cpu_pkg::addr_t rd_addr,
  output cpu_pkg::word_t rd_data
);

  localparam int DEPTH = 1 << `CPU_ADDR_BITS;  // 1024 words

  cpu_pkg::word_t mem [DEPTH];

  // port a, write only
  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // port b, registered read, old data on a same-address write
  always_ff @(posedge clka) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- src/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [15:0] word_t;                            // ram word and register value
  typedef logic [`CPU_ADDR_BITS-1:0] addr_t;              // logical or physical address
  typedef logic [$clog2(`CPU_NUM_PAGES)-1:0] page_t;      // page index
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;    // register number

  // kept opcodes, anything else decodes as a no-op
  typedef enum logic [7:0] {
    OP_JMP       = `CPU_OP_JMP,
    OP_RAM2REG   = `CPU_OP_RAM2REG,
    OP_REG2RAM   = `CPU_OP_REG2RAM,
    OP_NUM2REG   = `CPU_OP_NUM2REG,
    OP_REG_PLUS  = `CPU_OP_REG_PLUS,
    OP_REG_MINUS = `CPU_OP_REG_MINUS,
    OP_EXIT      = `CPU_OP_EXIT
  } opcode_t;

  // what a trace event reports
  typedef enum logic {
    TRACE_REG   = 1'b0,  // register write, index is the register number
    TRACE_STORE = 1'b1   // ram store, index is the physical address
  } trace_kind_t;

endpackage

//--- src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// address and memory geometry
`define CPU_ADDR_BITS 10      // logical and physical address width
`define CPU_PAGE_BITS 6       // offset bits, 64 words per page
`define CPU_NUM_PAGES 16      // physical pages in the RAM

// register file
`define CPU_NUM_REGS 8        // only the low reg field bits select one

// trace flow control
`define CPU_TRACE_CREDITS 4   // credits held by the trace port after reset

// opcode encoding, high byte of the first instruction word
`define CPU_OP_JMP       8'd1   // pc <= operand
`define CPU_OP_RAM2REG   8'd2   // reg <= ram[operand]
`define CPU_OP_REG2RAM   8'd3   // ram[operand] <= reg
`define CPU_OP_NUM2REG   8'd4   // reg <= operand
`define CPU_OP_REG_PLUS  8'd5   // reg <= reg + operand
`define CPU_OP_REG_MINUS 8'd6   // reg <= reg - operand
`define CPU_OP_EXIT      8'd17  // halt the core

// instruction layout
//   word 0: [15:8] opcode, [7:0] register field
//   word 1: 16-bit operand (value or address)
// every other opcode value runs as a no-op

`endif
